// ==== hw/flit_pkg.sv ====
package flit_pkg;

    // id of the destination device
    typedef logic [3:0] node_id_t;

    // sequence number, counted per source
    typedef logic [7:0] flit_id_t;

    // 13 bits in total
    typedef struct packed {
        node_id_t node_id;
        flit_id_t flit_id;
        // acks travel untracked
        logic     is_ack;
    } flit_header_t;

    // header in the upper bits, 45 bits in total
    typedef struct packed {
        flit_header_t header;
        logic [31:0]  payload;
    } flit_t;

endpackage

// ==== hw/retx_pkg.sv ====
package retx_pkg;

    // two bits cover a resend limit of up to three
    localparam int RESEND_CNT_W = 2;

    // largest limit the counter can represent
    localparam int RESEND_CNT_MAX = (1 << RESEND_CNT_W) - 1;

    typedef logic [RESEND_CNT_W-1:0] resend_cnt_t;

    // emitted once per flit that ran out of resends, 15 bits
    typedef struct packed {
        flit_pkg::flit_header_t header;
        resend_cnt_t            resend_num;
    } drop_report_t;

endpackage

// ==== hw/next_free_index_comb.sv ====
`timescale 1ns/10ps

module next_free_index_comb #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic [NUM_ENTRIES-1:0]         free_index_bitmap,
    output logic [$clog2(NUM_ENTRIES)-1:0] free_index,
    output logic                           free_index_valid
);
    typedef logic [$clog2(NUM_ENTRIES)-1:0] index_t;

    // walk down from the top so the lowest set bit is the one that sticks
    always_comb begin
        free_index = '0;
        for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
            if (free_index_bitmap[i]) begin
                free_index = index_t'(i);
            end
        end
    end

    assign free_index_valid = |free_index_bitmap;

endmodule

// ==== hw/elem_queue.sv ====
`timescale 1ns/10ps

module elem_queue #(
    parameter type elem_t = logic [7:0],
    parameter int NUM_ENTRIES = 8
) (
    input  logic  nocclk,
    input  logic  rst_n,

    input  elem_t pushed_element,
    input  logic  pushed_valid,
    output logic  pushed_ready,

    output elem_t poped_element,
    output logic  poped_valid,
    input  logic  poped_ready
);
    typedef logic [$clog2(NUM_ENTRIES)-1:0] ptr_t;
    typedef logic [$clog2(NUM_ENTRIES+1)-1:0] count_t;

    elem_t  mem [NUM_ENTRIES];
    ptr_t   rd_ptr;
    ptr_t   wr_ptr;
    count_t count;
    logic   push_fire;
    logic   pop_fire;

    // wrap at NUM_ENTRIES, which need not be a power of two
    function automatic ptr_t next_ptr(input ptr_t ptr);
        if (ptr == ptr_t'(NUM_ENTRIES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign pushed_ready  = (count != count_t'(NUM_ENTRIES));
    assign poped_valid   = (count != '0);
    assign poped_element = mem[rd_ptr];

    assign push_fire = pushed_valid && pushed_ready;
    assign pop_fire  = poped_valid && poped_ready;

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop_fire) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave the count unchanged
            if (push_fire && !pop_fire) begin
                count <= count + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge nocclk) begin
        if (push_fire) begin
            mem[wr_ptr] <= pushed_element;
        end
    end

endmodule

// ==== hw/waiting_ack_controller.sv ====
`timescale 1ns/10ps

module waiting_ack_controller #(
    parameter int ACK_BUFFER_NUM_ENTRIES = 8,
    parameter int MAX_RESEND_NUM = 3,
    parameter int MAX_TIMEOUT = 100
) (
    input  logic                   nocclk,
    input  logic                   rst_n,

    input  flit_pkg::flit_t        tx_flit,
    input  logic                   tx_fire,

    input  flit_pkg::flit_t        ack_flit,
    input  logic                   ack_valid,

    output logic                   entry_free,

    output flit_pkg::flit_t        resend_flit,
    output logic                   resend_valid,
    input  logic                   resend_ready,

    output retx_pkg::drop_report_t drop,
    output logic                   drop_valid
);
    import flit_pkg::*;
    import retx_pkg::*;

    localparam int N = ACK_BUFFER_NUM_ENTRIES;
    localparam int IDX_W = $clog2(ACK_BUFFER_NUM_ENTRIES);
    // the limit cannot exceed what the counter holds
    localparam int RESEND_LIMIT =
        (MAX_RESEND_NUM < RESEND_CNT_MAX) ? MAX_RESEND_NUM : RESEND_CNT_MAX;

    typedef logic [IDX_W-1:0] index_t;
    typedef logic [$clog2(MAX_TIMEOUT+1)-1:0] timer_t;

    localparam timer_t      TIMEOUT_VAL = timer_t'(MAX_TIMEOUT);
    localparam resend_cnt_t RESEND_LAST = resend_cnt_t'(RESEND_LIMIT);

    typedef struct packed {
        logic        resending;
        logic        acked;
        resend_cnt_t resend_num;
        timer_t      timer;
    } entry_ctrl_t;

    entry_ctrl_t    ctrl_q [N];
    flit_t          flit_mem [N];
    logic [N-1:0]   free_bitmap;

    logic [N-1:0]   ack_hit;
    logic [N-1:0]   expired;
    logic [N-1:0]   timeout_map;
    logic [N-1:0]   drop_map;

    index_t         free_index;
    logic           free_index_valid;
    index_t         push_index;
    logic           push_valid;
    logic           push_ready;
    index_t         drop_index;
    logic           drop_any;

    index_t         head_index;
    logic           head_valid;
    logic           head_skip;
    logic           head_done;
    logic           resend_fire;
    logic           offer_q;
    logic           alloc;

    next_free_index_comb #(
        .NUM_ENTRIES(N)
    ) free_pick (
        .free_index_bitmap(free_bitmap),
        .free_index       (free_index),
        .free_index_valid (free_index_valid)
    );

    // lowest expired entry gets the push, the rest wait at MAX_TIMEOUT
    next_free_index_comb #(
        .NUM_ENTRIES(N)
    ) timeout_pick (
        .free_index_bitmap(timeout_map),
        .free_index       (push_index),
        .free_index_valid (push_valid)
    );

    next_free_index_comb #(
        .NUM_ENTRIES(N)
    ) drop_pick (
        .free_index_bitmap(drop_map),
        .free_index       (drop_index),
        .free_index_valid (drop_any)
    );

    elem_queue #(
        .elem_t     (index_t),
        .NUM_ENTRIES(N)
    ) resend_queue (
        .nocclk        (nocclk),
        .rst_n         (rst_n),
        .pushed_element(push_index),
        .pushed_valid  (push_valid),
        .pushed_ready  (push_ready),
        .poped_element (head_index),
        .poped_valid   (head_valid),
        .poped_ready   (head_done)
    );

    // ack match on node and flit id, occupied entries only
    always_comb begin
        for (int i = 0; i < N; i++) begin
            ack_hit[i] = !free_bitmap[i] && ack_valid
                && (flit_mem[i].header.node_id == ack_flit.header.node_id)
                && (flit_mem[i].header.flit_id == ack_flit.header.flit_id);
            expired[i] = !free_bitmap[i] && !ctrl_q[i].resending && !ack_hit[i]
                && (ctrl_q[i].timer == TIMEOUT_VAL);
            timeout_map[i] = expired[i] && (ctrl_q[i].resend_num < RESEND_LAST);
            drop_map[i]    = expired[i] && (ctrl_q[i].resend_num >= RESEND_LAST);
        end
    end

    // an acked head that was never offered is popped silently
    assign head_skip    = head_valid && ctrl_q[head_index].acked && !offer_q;
    assign resend_valid = head_valid && !head_skip;
    assign resend_flit  = flit_mem[head_index];
    assign resend_fire  = resend_valid && resend_ready;
    assign head_done    = resend_fire || head_skip;

    // a resend on the link is already tracked
    assign alloc = tx_fire && !tx_flit.header.is_ack && !resend_fire && free_index_valid;

    assign entry_free = free_index_valid;

    assign drop_valid = drop_any;

    always_comb begin
        drop.header     = flit_mem[drop_index].header;
        drop.resend_num = ctrl_q[drop_index].resend_num;
    end

    always_ff @(posedge nocclk) begin
        if (!rst_n) begin
            free_bitmap <= '1;
            offer_q     <= 1'b0;
            for (int i = 0; i < N; i++) begin
                ctrl_q[i] <= '0;
            end
        end else begin
            // once offered, a resend stays on offer until it transfers
            offer_q <= resend_valid && !resend_ready;
            for (int i = 0; i < N; i++) begin
                if (free_bitmap[i]) begin
                    if (alloc && (free_index == index_t'(i))) begin
                        free_bitmap[i] <= 1'b0;
                        ctrl_q[i]      <= '0;
                    end
                end else if (head_done && (head_index == index_t'(i))) begin
                    if (ctrl_q[i].acked || ack_hit[i]) begin
                        free_bitmap[i] <= 1'b1;
                        ctrl_q[i]      <= '0;
                    end else begin
                        ctrl_q[i].resending  <= 1'b0;
                        ctrl_q[i].resend_num <= ctrl_q[i].resend_num + 1'b1;
                        ctrl_q[i].timer      <= '0;
                    end
                end else if (ctrl_q[i].resending) begin
                    // index sits in the queue, so release waits for its pop
                    if (ack_hit[i]) begin
                        ctrl_q[i].acked <= 1'b1;
                    end
                end else if (ack_hit[i] || (drop_any && (drop_index == index_t'(i)))) begin
                    free_bitmap[i] <= 1'b1;
                    ctrl_q[i]      <= '0;
                end else if (ctrl_q[i].timer < TIMEOUT_VAL) begin
                    ctrl_q[i].timer <= ctrl_q[i].timer + 1'b1;
                end else if (push_valid && push_ready && (push_index == index_t'(i))) begin
                    ctrl_q[i].resending <= 1'b1;
                end
            end
        end
    end

    // copy of every tracked flit, read back for resends and drop reports
    always_ff @(posedge nocclk) begin
        if (alloc) begin
            flit_mem[free_index] <= tx_flit;
        end
    end

endmodule

// ==== hw/link_tx_mux.sv ====
`timescale 1ns/10ps

module link_tx_mux (
    input  flit_pkg::flit_t local_flit,
    input  logic            local_valid,
    output logic            local_ready,

    input  flit_pkg::flit_t resend_flit,
    input  logic            resend_valid,
    output logic            resend_ready,

    input  logic            entry_free,

    output flit_pkg::flit_t link_flit,
    output logic            link_valid,
    input  logic            link_ready,

    output flit_pkg::flit_t tx_flit,
    output logic            tx_fire
);
    import flit_pkg::*;

    logic local_ok;
    logic local_is_ack;

    assign local_is_ack = local_flit.header.is_ack;

    // data flits need a free ack buffer slot, acks go through regardless
    assign local_ok = local_valid && (local_is_ack || entry_free);

    // resends have strict priority over local traffic
    assign link_valid = resend_valid || local_ok;

    always_comb begin
        if (resend_valid) begin
            link_flit = resend_flit;
        end else begin
            link_flit = local_flit;
        end
    end

    assign resend_ready = link_ready;

    // held off while a resend owns the link or the buffer is full
    assign local_ready = link_ready && !resend_valid && (local_is_ack || entry_free);

    // every completed transfer goes back to the controller
    assign tx_flit = link_flit;
    assign tx_fire = link_valid && link_ready;

endmodule

// ==== hw/link_retx_top.sv ====
`timescale 1ns/10ps

module link_retx_top #(
    parameter int ACK_BUFFER_NUM_ENTRIES = 8,
    parameter int MAX_RESEND_NUM = 3,
    parameter int MAX_TIMEOUT = 100
) (
    input  logic                   nocclk,
    input  logic                   rst_n,

    input  flit_pkg::flit_t        local_flit,
    input  logic                   local_valid,
    output logic                   local_ready,

    output flit_pkg::flit_t        link_flit,
    output logic                   link_valid,
    input  logic                   link_ready,

    input  flit_pkg::flit_t        ack_flit,
    input  logic                   ack_valid,

    output retx_pkg::drop_report_t drop,
    output logic                   drop_valid
);
    import flit_pkg::*;

    logic  entry_free;
    flit_t resend_flit;
    logic  resend_valid;
    logic  resend_ready;
    flit_t tx_flit;
    logic  tx_fire;

    waiting_ack_controller #(
        .ACK_BUFFER_NUM_ENTRIES(ACK_BUFFER_NUM_ENTRIES),
        .MAX_RESEND_NUM        (MAX_RESEND_NUM),
        .MAX_TIMEOUT           (MAX_TIMEOUT)
    ) ctrl0 (
        .nocclk      (nocclk),
        .rst_n       (rst_n),
        .tx_flit     (tx_flit),
        .tx_fire     (tx_fire),
        .ack_flit    (ack_flit),
        .ack_valid   (ack_valid),
        .entry_free  (entry_free),
        .resend_flit (resend_flit),
        .resend_valid(resend_valid),
        .resend_ready(resend_ready),
        .drop        (drop),
        .drop_valid  (drop_valid)
    );

    link_tx_mux mux0 (
        .local_flit  (local_flit),
        .local_valid (local_valid),
        .local_ready (local_ready),
        .resend_flit (resend_flit),
        .resend_valid(resend_valid),
        .resend_ready(resend_ready),
        .entry_free  (entry_free),
        .link_flit   (link_flit),
        .link_valid  (link_valid),
        .link_ready  (link_ready),
        .tx_flit     (tx_flit),
        .tx_fire     (tx_fire)
    );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic nocclk,
    output logic rst_n
);
    initial begin
        nocclk = 1'b0;
        forever #(PERIOD_NS / 2) nocclk = ~nocclk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge nocclk);
        @(negedge nocclk);
        rst_n = 1'b1;
    end

endmodule

// ==== test/link_retx_tb.sv ====
`timescale 1ns/10ps

module link_retx_tb;
    import flit_pkg::*;
    import retx_pkg::*;

    localparam int NUM_ENTRIES = 8;
    localparam int RESEND_NUM = 3;
    localparam int TIMEOUT = 24;
    localparam int NUM_FLITS = 120;
    localparam int FLIT_WAIT_MAX = 3000;
    localparam int DRAIN_MAX = 4000;
    localparam int RESET_WAIT_MAX = 100;

    logic         nocclk;
    logic         rst_n;
    flit_t        local_flit;
    logic         local_valid;
    logic         local_ready;
    flit_t        link_flit;
    logic         link_valid;
    logic         link_ready;
    flit_t        ack_flit;
    logic         ack_valid;
    drop_report_t drop;
    logic         drop_valid;

    // model of every flit indexed by flit_id
    flit_t sent_flit [256];
    logic  tracked [256];
    logic  resolved [256];
    logic  silent [256];
    logic  ack_done [256];
    int    last_tx [256];
    int    resends [256];
    int    ack_due [256];
    int    ack_delay [256];

    logic [15:0] lfsr_state;
    int    cycle_cnt;
    int    outstanding;
    int    mismatch_cnt;
    int    other_cnt;
    int    accepted;
    int    drops_seen;
    int    next_id;
    logic  local_taken;
    logic  held_valid;
    flit_t held_flit;

    tb_clock_gen #(
        .PERIOD_NS   (40),
        .RESET_CYCLES(16)
    ) clk0 (
        .nocclk(nocclk),
        .rst_n (rst_n)
    );

    link_retx_top #(
        .ACK_BUFFER_NUM_ENTRIES(NUM_ENTRIES),
        .MAX_RESEND_NUM        (RESEND_NUM),
        .MAX_TIMEOUT           (TIMEOUT)
    ) dut0 (
        .nocclk     (nocclk),
        .rst_n      (rst_n),
        .local_flit (local_flit),
        .local_valid(local_valid),
        .local_ready(local_ready),
        .link_flit  (link_flit),
        .link_valid (link_valid),
        .link_ready (link_ready),
        .ack_flit   (ack_flit),
        .ack_valid  (ack_valid),
        .drop       (drop),
        .drop_valid (drop_valid)
    );

    // galois lfsr stepped once per bit
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check_flit(input string what, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_drop(input drop_report_t got, input drop_report_t exp);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("mismatch at %0t: drop report got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        other_cnt++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // stimulus for one falling edge covers link stalls, far-end acks and local flits
    task automatic drive_cycle();
        logic  found;
        flit_t f;
        link_ready = (rand_bits(2) != 0);
        ack_valid = 1'b0;
        found = 1'b0;
        for (int id = 0; id < 256; id++) begin
            if (!found && tracked[id] && !silent[id] && !ack_done[id]
                    && (ack_due[id] <= cycle_cnt)) begin
                found = 1'b1;
                ack_done[id] = 1'b1;
                ack_valid = 1'b1;
                ack_flit.header.node_id = sent_flit[id].header.node_id;
                ack_flit.header.flit_id = sent_flit[id].header.flit_id;
                ack_flit.header.is_ack = 1'b1;
            end
        end
        if (local_taken) begin
            local_valid = 1'b0;
            local_taken = 1'b0;
        end
        if (!local_valid && (next_id < NUM_FLITS)) begin
            f.header.node_id = node_id_t'(rand_bits(4));
            f.header.flit_id = flit_id_t'(next_id);
            f.header.is_ack = (rand_bits(3) == 0);
            f.payload = rand_bits(32);
            silent[next_id] = !f.header.is_ack && (rand_bits(2) == 0);
            ack_delay[next_id] = 1 + int'(rand_bits(3));
            local_flit = f;
            local_valid = 1'b1;
            next_id++;
        end
    endtask

    always @(posedge nocclk) begin : monitor
        int id;
        drop_report_t drop_exp;
        if (rst_n) begin
            cycle_cnt++;
            // a stalled resend must stay on the link unchanged
            if (held_valid) begin
                if (!link_valid) begin
                    report_error("link_valid dropped while a resend was stalled");
                end else begin
                    check_flit("stalled link_flit", link_flit, held_flit);
                end
            end
            held_valid = link_valid && !link_ready && !(local_valid && link_flit === local_flit);
            held_flit = link_flit;
            if (local_valid && local_ready && !local_flit.header.is_ack
                    && (outstanding >= NUM_ENTRIES)) begin
                report_error("data flit accepted while the ack buffer was full");
            end
            // an ack flit or a data flit with room left waits only behind a resend
            if (local_valid && link_ready && !local_ready
                    && (local_flit.header.is_ack || (outstanding < NUM_ENTRIES))
                    && !(link_valid && (link_flit !== local_flit))) begin
                report_error("local flit was held back while the link was free");
            end
            if (ack_valid) begin
                id = ack_flit.header.flit_id;
                if (tracked[id] && !resolved[id]) begin
                    resolved[id] = 1'b1;
                    outstanding--;
                end
            end
            if (drop_valid) begin
                id = drop.header.flit_id;
                if (!tracked[id] || resolved[id]) begin
                    report_error("drop report for a flit that is not outstanding");
                end else begin
                    drop_exp.header = sent_flit[id].header;
                    drop_exp.resend_num = resend_cnt_t'(RESEND_NUM);
                    check_drop(drop, drop_exp);
                    if (!silent[id]) begin
                        report_error("acked flit was reported as dropped");
                    end
                    if (resends[id] != RESEND_NUM) begin
                        report_error("drop came before all resends were seen");
                    end
                    if (cycle_cnt - last_tx[id] < TIMEOUT) begin
                        report_error("drop came before the final timeout");
                    end
                    resolved[id] = 1'b1;
                    outstanding--;
                    drops_seen++;
                end
            end
            if (link_valid && link_ready) begin
                if (local_valid && local_ready) begin
                    check_flit("local flit on link", link_flit, local_flit);
                    id = local_flit.header.flit_id;
                    accepted++;
                    local_taken = 1'b1;
                    if (!local_flit.header.is_ack) begin
                        tracked[id] = 1'b1;
                        sent_flit[id] = local_flit;
                        last_tx[id] = cycle_cnt;
                        resends[id] = 0;
                        outstanding++;
                        ack_due[id] = cycle_cnt + ack_delay[id];
                    end
                end else begin
                    id = link_flit.header.flit_id;
                    if (!tracked[id]) begin
                        report_error("resend of a flit that was never tracked");
                    end else if (resolved[id]) begin
                        report_error("resend of a flit that was already released");
                    end else begin
                        check_flit("resent flit", link_flit, sent_flit[id]);
                        if (resends[id] >= RESEND_NUM) begin
                            report_error("flit resent more often than allowed");
                        end
                        if (cycle_cnt - last_tx[id] < TIMEOUT) begin
                            report_error("resend came before the timeout");
                        end
                        resends[id]++;
                        last_tx[id] = cycle_cnt;
                    end
                end
            end
        end
    end

    initial begin
        int   wait_cnt;
        logic timed_out;
        lfsr_state = 16'd29114;
        local_flit = '0;
        local_valid = 1'b0;
        link_ready = 1'b0;
        ack_flit = '0;
        ack_valid = 1'b0;
        cycle_cnt = 0;
        outstanding = 0;
        mismatch_cnt = 0;
        other_cnt = 0;
        accepted = 0;
        drops_seen = 0;
        next_id = 0;
        local_taken = 1'b0;
        held_valid = 1'b0;
        held_flit = '0;
        timed_out = 1'b0;
        for (int i = 0; i < 256; i++) begin
            tracked[i] = 1'b0;
            resolved[i] = 1'b0;
            silent[i] = 1'b0;
            ack_done[i] = 1'b0;
            ack_due[i] = 0;
        end

        wait_cnt = 0;
        while (!rst_n && (wait_cnt < RESET_WAIT_MAX)) begin
            @(negedge nocclk);
            wait_cnt++;
        end
        if (!rst_n) begin
            report_error("reset was never released");
            timed_out = 1'b1;
        end

        // send all local flits with a fresh acceptance timeout for each
        wait_cnt = 0;
        while (!timed_out && ((next_id < NUM_FLITS) || local_valid)) begin
            @(negedge nocclk);
            if (local_taken) begin
                wait_cnt = 0;
            end
            drive_cycle();
            wait_cnt++;
            if (wait_cnt > FLIT_WAIT_MAX) begin
                report_error("local flit was not accepted in time");
                timed_out = 1'b1;
            end
        end

        // let every tracked flit resolve by ack or drop
        wait_cnt = 0;
        while (!timed_out && (outstanding != 0)) begin
            @(negedge nocclk);
            drive_cycle();
            wait_cnt++;
            if (wait_cnt > DRAIN_MAX) begin
                report_error("tracked flits were not resolved in time");
                timed_out = 1'b1;
            end
        end

        if (!timed_out && (accepted != NUM_FLITS)) begin
            report_error("not every local flit reached the link");
        end
        $display("mismatches %0d, other errors %0d, flits %0d, drops %0d",
            mismatch_cnt, other_cnt, accepted, drops_seen);
        if ((mismatch_cnt == 0) && (other_cnt == 0)) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hw/flit_pkg.sv
hw/retx_pkg.sv
hw/next_free_index_comb.sv
hw/elem_queue.sv
hw/waiting_ack_controller.sv
hw/link_tx_mux.sv
hw/link_retx_top.sv
test/tb_clock_gen.sv
test/link_retx_tb.sv
